// ==== Makefile ====
TOP = tb_adp_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== hdl/adp_axil_arbiter.sv ====
`timescale 1ns/1ps

module adp_axil_arbiter (
  input  logic               tck,
  input  logic               rst_n,
  // Debug master side
  input  adp_pkg::adp_addr_t dm_awaddr,
  input  logic               dm_awvalid,
  output logic               dm_awready,
  input  adp_pkg::adp_data_t dm_wdata,
  input  logic               dm_wvalid,
  output logic               dm_wready,
  output adp_pkg::adp_resp_t dm_bresp,
  output logic               dm_bvalid,
  input  logic               dm_bready,
  input  adp_pkg::adp_addr_t dm_araddr,
  input  logic               dm_arvalid,
  output logic               dm_arready,
  output adp_pkg::adp_data_t dm_rdata,
  output adp_pkg::adp_resp_t dm_rresp,
  output logic               dm_rvalid,
  input  logic               dm_rready,
  // Processor side
  input  adp_pkg::adp_addr_t cpu_awaddr,
  input  logic               cpu_awvalid,
  output logic               cpu_awready,
  input  adp_pkg::adp_data_t cpu_wdata,
  input  logic               cpu_wvalid,
  output logic               cpu_wready,
  output adp_pkg::adp_resp_t cpu_bresp,
  output logic               cpu_bvalid,
  input  logic               cpu_bready,
  input  adp_pkg::adp_addr_t cpu_araddr,
  input  logic               cpu_arvalid,
  output logic               cpu_arready,
  output adp_pkg::adp_data_t cpu_rdata,
  output adp_pkg::adp_resp_t cpu_rresp,
  output logic               cpu_rvalid,
  input  logic               cpu_rready,
  // Shared bus toward the target
  output adp_pkg::adp_addr_t m_awaddr,
  output logic               m_awvalid,
  input  logic               m_awready,
  output adp_pkg::adp_data_t m_wdata,
  output logic               m_wvalid,
  input  logic               m_wready,
  input  adp_pkg::adp_resp_t m_bresp,
  input  logic               m_bvalid,
  output logic               m_bready,
  output adp_pkg::adp_addr_t m_araddr,
  output logic               m_arvalid,
  input  logic               m_arready,
  input  adp_pkg::adp_data_t m_rdata,
  input  adp_pkg::adp_resp_t m_rresp,
  input  logic               m_rvalid,
  output logic               m_rready
);
  import adp_pkg::*;

  localparam logic OWN_DM  = 1'b0;
  localparam logic OWN_CPU = 1'b1;

  logic busy;
  logic owner;
  logic rr_next;
  logic sel;
  logic dm_req;
  logic cpu_req;
  logic release_bus;

  assign dm_req      = dm_awvalid || dm_arvalid;
  assign cpu_req     = cpu_awvalid || cpu_arvalid;
  assign release_bus = (m_bvalid && m_bready) || (m_rvalid && m_rready);

  ////////////////////////////////////////////////////////////
  // Grant
  ////////////////////////////////////////////////////////////

  // When idle the grant is combinational so no cycle is lost
  // A tie goes to rr_next
  always_comb begin
    if (busy) begin
      sel = owner;
    end else if (dm_req && cpu_req) begin
      sel = rr_next;
    end else if (cpu_req) begin
      sel = OWN_CPU;
    end else begin
      sel = OWN_DM;
    end
  end

  // Ownership ends with the B or R handshake
  always_ff @(posedge tck) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      owner   <= OWN_DM;
      rr_next <= OWN_DM;
    end else if (busy) begin
      if (release_bus) begin
        busy    <= 1'b0;
        rr_next <= !owner;
      end
    end else if (dm_req || cpu_req) begin
      busy  <= 1'b1;
      owner <= sel;
    end
  end

  ////////////////////////////////////////////////////////////
  // Routing
  ////////////////////////////////////////////////////////////

  // Request channels come from the selected master
  assign m_awaddr  = (sel == OWN_CPU) ? cpu_awaddr  : dm_awaddr;
  assign m_awvalid = (sel == OWN_CPU) ? cpu_awvalid : dm_awvalid;
  assign m_wdata   = (sel == OWN_CPU) ? cpu_wdata   : dm_wdata;
  assign m_wvalid  = (sel == OWN_CPU) ? cpu_wvalid  : dm_wvalid;
  assign m_bready  = (sel == OWN_CPU) ? cpu_bready  : dm_bready;
  assign m_araddr  = (sel == OWN_CPU) ? cpu_araddr  : dm_araddr;
  assign m_arvalid = (sel == OWN_CPU) ? cpu_arvalid : dm_arvalid;
  assign m_rready  = (sel == OWN_CPU) ? cpu_rready  : dm_rready;

  // Handshake signals reach only the selected master
  assign dm_awready  = m_awready && (sel == OWN_DM);
  assign dm_wready   = m_wready  && (sel == OWN_DM);
  assign dm_bvalid   = m_bvalid  && (sel == OWN_DM);
  assign dm_arready  = m_arready && (sel == OWN_DM);
  assign dm_rvalid   = m_rvalid  && (sel == OWN_DM);
  assign cpu_awready = m_awready && (sel == OWN_CPU);
  assign cpu_wready  = m_wready  && (sel == OWN_CPU);
  assign cpu_bvalid  = m_bvalid  && (sel == OWN_CPU);
  assign cpu_arready = m_arready && (sel == OWN_CPU);
  assign cpu_rvalid  = m_rvalid  && (sel == OWN_CPU);

  // Response payload fans out, qualified by valid
  assign dm_bresp  = m_bresp;
  assign dm_rdata  = m_rdata;
  assign dm_rresp  = m_rresp;
  assign cpu_bresp = m_bresp;
  assign cpu_rdata = m_rdata;
  assign cpu_rresp = m_rresp;

endmodule

// ==== hdl/adp_debug_master.sv ====
`timescale 1ns/1ps

module adp_debug_master (
  input  logic               tck,
  input  logic               rst_n,
  input  logic               dbg_req,
  input  logic               dbg_we,
  input  adp_pkg::adp_addr_t dbg_addr,
  input  adp_pkg::adp_data_t dbg_wdata,
  output logic               dbg_done,
  output adp_pkg::adp_data_t dbg_rdata,
  output logic               dbg_busy,
  // AXI4-Lite master
  output adp_pkg::adp_addr_t dm_awaddr,
  output logic               dm_awvalid,
  input  logic               dm_awready,
  output adp_pkg::adp_data_t dm_wdata,
  output logic               dm_wvalid,
  input  logic               dm_wready,
  input  adp_pkg::adp_resp_t dm_bresp,
  input  logic               dm_bvalid,
  output logic               dm_bready,
  output adp_pkg::adp_addr_t dm_araddr,
  output logic               dm_arvalid,
  input  logic               dm_arready,
  input  adp_pkg::adp_data_t dm_rdata,
  input  adp_pkg::adp_resp_t dm_rresp,
  input  logic               dm_rvalid,
  output logic               dm_rready
);
  import adp_pkg::*;

  typedef enum logic [2:0] {
    DM_IDLE,
    DM_WRITE,
    DM_WRESP,
    DM_READ,
    DM_RDATA
  } dm_state_t;

  dm_state_t state;

  // Request payload, captured once per access
  always_ff @(posedge tck) begin
    if (state == DM_IDLE && dbg_req) begin
      dm_awaddr <= dbg_addr;
      dm_wdata  <= dbg_wdata;
    end
  end

  assign dm_araddr = dm_awaddr;

  always_ff @(posedge tck) begin
    if (!rst_n) begin
      state      <= DM_IDLE;
      dm_awvalid <= 1'b0;
      dm_wvalid  <= 1'b0;
      dm_arvalid <= 1'b0;
    end else begin
      case (state)
        DM_IDLE: begin
          if (dbg_req && dbg_we) begin
            state      <= DM_WRITE;
            dm_awvalid <= 1'b1;
            dm_wvalid  <= 1'b1;
          end else if (dbg_req) begin
            state      <= DM_READ;
            dm_arvalid <= 1'b1;
          end
        end
        // AW and W may complete apart
        DM_WRITE: begin
          if (dm_awready) begin
            dm_awvalid <= 1'b0;
          end
          if (dm_wready) begin
            dm_wvalid <= 1'b0;
          end
          if ((!dm_awvalid || dm_awready) && (!dm_wvalid || dm_wready)) begin
            state <= DM_WRESP;
          end
        end
        DM_WRESP: begin
          if (dm_bvalid) begin
            state <= DM_IDLE;
          end
        end
        DM_READ: begin
          if (dm_arready) begin
            dm_arvalid <= 1'b0;
            state      <= DM_RDATA;
          end
        end
        DM_RDATA: begin
          if (dm_rvalid) begin
            state <= DM_IDLE;
          end
        end
        default: state <= DM_IDLE;
      endcase
    end
  end

  assign dm_bready = (state == DM_WRESP);
  assign dm_rready = (state == DM_RDATA);

  // Done in the response handshake cycle
  assign dbg_done = (dm_bready && dm_bvalid) || (dm_rready && dm_rvalid);
  assign dbg_busy = dbg_req || (state != DM_IDLE);

  // Failed reads give zero, a write completion carries its B response
  assign dbg_rdata = (state != DM_RDATA) ? adp_data_t'(dm_bresp) :
                     (dm_rresp == 2'b00) ? dm_rdata : '0;

endmodule

// ==== hdl/adp_debug_target.sv ====
`timescale 1ns/1ps
`include "adp_settings.svh"

module adp_debug_target (
  input  logic               tck,
  input  logic               rst_n,
  input  adp_pkg::adp_addr_t m_awaddr,
  input  logic               m_awvalid,
  output logic               m_awready,
  input  adp_pkg::adp_data_t m_wdata,
  input  logic               m_wvalid,
  output logic               m_wready,
  output adp_pkg::adp_resp_t m_bresp,
  output logic               m_bvalid,
  input  logic               m_bready,
  input  adp_pkg::adp_addr_t m_araddr,
  input  logic               m_arvalid,
  output logic               m_arready,
  output adp_pkg::adp_data_t m_rdata,
  output adp_pkg::adp_resp_t m_rresp,
  output logic               m_rvalid,
  input  logic               m_rready
);
  import adp_pkg::*;

  localparam adp_resp_t RESP_OKAY   = 2'b00;
  localparam adp_resp_t RESP_DECERR = 2'b11;
  localparam int        REG_IDX_W   = 5;
  localparam adp_addr_t SRAM_MASK   = adp_addr_t'((1 << `ADP_SRAM_ADDR_WIDTH) - 1);
  localparam adp_addr_t REG_MASK    = adp_addr_t'((1 << REG_IDX_W) - 1);

  typedef enum logic [2:0] {
    RGN_SRAM,
    RGN_REG,
    RGN_PC,
    RGN_IR,
    RGN_NONE
  } region_t;

  adp_data_t            sram [2**`ADP_SRAM_ADDR_WIDTH];
  adp_data_t            regs [2**REG_IDX_W];
  adp_data_t            pc_q;
  adp_data_t            instr_q;
  region_t              wr_rgn;
  region_t              rd_rgn;
  logic [REG_IDX_W-1:0] wr_idx;
  logic [REG_IDX_W-1:0] rd_idx;

  // Address map decode
  function automatic region_t decode(adp_addr_t addr);
    if ((addr & ~SRAM_MASK) == `ADP_SRAM_BASE) return RGN_SRAM;
    if ((addr & ~REG_MASK) == `ADP_REG_BASE) return RGN_REG;
    if (addr == `ADP_PC_ADDR) return RGN_PC;
    if (addr == `ADP_IR_ADDR) return RGN_IR;
    return RGN_NONE;
  endfunction

  assign wr_rgn = decode(m_awaddr);
  assign rd_rgn = decode(m_araddr);
  assign wr_idx = m_awaddr[REG_IDX_W-1:0];
  assign rd_idx = m_araddr[REG_IDX_W-1:0];

  ////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////

  // AW/W ready one cycle after both valid, B one cycle later
  // AR ready one cycle after valid, R one cycle later
  always_ff @(posedge tck) begin
    if (!rst_n) begin
      m_awready <= 1'b0;
      m_wready  <= 1'b0;
      m_bvalid  <= 1'b0;
      m_arready <= 1'b0;
      m_rvalid  <= 1'b0;
    end else begin
      m_awready <= m_awvalid && m_wvalid && !m_awready && !m_bvalid;
      m_wready  <= m_awvalid && m_wvalid && !m_awready && !m_bvalid;
      if (m_awready) begin
        m_bvalid <= 1'b1;
      end else if (m_bready) begin
        m_bvalid <= 1'b0;
      end
      m_arready <= m_arvalid && !m_arready && !m_rvalid;
      if (m_arready) begin
        m_rvalid <= 1'b1;
      end else if (m_rready) begin
        m_rvalid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // Writes commit in the AW/W handshake cycle
  // Register 0 is hardwired, unmapped writes vanish
  always_ff @(posedge tck) begin
    if (m_awready) begin
      m_bresp <= RESP_OKAY;
      case (wr_rgn)
        RGN_SRAM: sram[m_awaddr[`ADP_SRAM_ADDR_WIDTH-1:0]] <= m_wdata;
        RGN_REG: begin
          if (wr_idx != '0) begin
            regs[wr_idx] <= m_wdata;
          end
        end
        RGN_PC:  pc_q    <= m_wdata;
        RGN_IR:  instr_q <= m_wdata;
        default: m_bresp <= RESP_DECERR;
      endcase
    end
  end

  // Read data sampled in the AR handshake cycle
  always_ff @(posedge tck) begin
    if (m_arready) begin
      m_rresp <= RESP_OKAY;
      case (rd_rgn)
        RGN_SRAM: m_rdata <= sram[m_araddr[`ADP_SRAM_ADDR_WIDTH-1:0]];
        RGN_REG:  m_rdata <= (rd_idx == '0) ? '0 : regs[rd_idx];
        RGN_PC:   m_rdata <= pc_q;
        RGN_IR:   m_rdata <= instr_q;
        default: begin
          m_rdata <= '0;
          m_rresp <= RESP_DECERR;
        end
      endcase
    end
  end

endmodule

// ==== hdl/adp_pkg.sv ====
`include "adp_settings.svh"

package adp_pkg;

  // One debug or bus address
  typedef logic [`ADP_ADDR_WIDTH-1:0] adp_addr_t;
  // One data word
  typedef logic [`ADP_DATA_WIDTH-1:0] adp_data_t;
  // TAP instruction
  typedef logic [`ADP_IR_WIDTH-1:0]   adp_instr_t;
  // AXI response code
  typedef logic [1:0]                 adp_resp_t;

  // IEEE 1149.1 controller states
  typedef enum logic [3:0] {
    TEST_LOGIC_RESET,
    RUN_TEST_IDLE,
    SELECT_DR_SCAN,
    CAPTURE_DR,
    SHIFT_DR,
    EXIT1_DR,
    PAUSE_DR,
    EXIT2_DR,
    UPDATE_DR,
    SELECT_IR_SCAN,
    CAPTURE_IR,
    SHIFT_IR,
    EXIT1_IR,
    PAUSE_IR,
    EXIT2_IR,
    UPDATE_IR
  } tap_state_t;

endpackage

// ==== hdl/adp_tap.sv ====
`timescale 1ns/1ps
`include "adp_settings.svh"

module adp_tap (
  input  logic               tck,
  input  logic               rst_n,
  input  logic               tms,
  input  logic               tdi,
  output logic               tdo,
  output logic               dbg_req,
  output logic               dbg_we,
  output adp_pkg::adp_addr_t dbg_addr,
  output adp_pkg::adp_data_t dbg_wdata,
  input  logic               dbg_done,
  input  adp_pkg::adp_data_t dbg_rdata
);
  import adp_pkg::*;

  tap_state_t state;
  tap_state_t state_nxt;
  adp_instr_t ir;
  adp_instr_t ir_sr;
  adp_data_t  idcode_sr;
  adp_data_t  data_sr;
  adp_addr_t  addr_sr;
  logic       bypass_sr;
  logic       sel_addr;
  logic       sel_data;
  logic       dr_lsb;

  ////////////////////////////////////////////////////////////
  // TAP controller
  ////////////////////////////////////////////////////////////

  always_ff @(posedge tck) begin
    if (!rst_n) begin
      state <= TEST_LOGIC_RESET;
    end else begin
      state <= state_nxt;
    end
  end

  // Five TMS ones from anywhere land in Test-Logic-Reset
  always_comb begin
    case (state)
      TEST_LOGIC_RESET: state_nxt = tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
      RUN_TEST_IDLE:    state_nxt = tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
      SELECT_DR_SCAN:   state_nxt = tms ? SELECT_IR_SCAN   : CAPTURE_DR;
      CAPTURE_DR:       state_nxt = tms ? EXIT1_DR         : SHIFT_DR;
      SHIFT_DR:         state_nxt = tms ? EXIT1_DR         : SHIFT_DR;
      EXIT1_DR:         state_nxt = tms ? UPDATE_DR        : PAUSE_DR;
      PAUSE_DR:         state_nxt = tms ? EXIT2_DR         : PAUSE_DR;
      EXIT2_DR:         state_nxt = tms ? UPDATE_DR        : SHIFT_DR;
      UPDATE_DR:        state_nxt = tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
      SELECT_IR_SCAN:   state_nxt = tms ? TEST_LOGIC_RESET : CAPTURE_IR;
      CAPTURE_IR:       state_nxt = tms ? EXIT1_IR         : SHIFT_IR;
      SHIFT_IR:         state_nxt = tms ? EXIT1_IR         : SHIFT_IR;
      EXIT1_IR:         state_nxt = tms ? UPDATE_IR        : PAUSE_IR;
      PAUSE_IR:         state_nxt = tms ? EXIT2_IR         : PAUSE_IR;
      EXIT2_IR:         state_nxt = tms ? UPDATE_IR        : SHIFT_IR;
      UPDATE_IR:        state_nxt = tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
      default:          state_nxt = TEST_LOGIC_RESET;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Instruction register
  ////////////////////////////////////////////////////////////

  // IDCODE is the power-up and TAP-reset instruction
  always_ff @(posedge tck) begin
    if (!rst_n || state == TEST_LOGIC_RESET) begin
      ir <= `ADP_IR_DEVICE_ID_READ;
    end else if (state == UPDATE_IR) begin
      ir <= ir_sr;
    end
  end

  // Capture loads the mandatory 01 pattern in the low bits
  always_ff @(posedge tck) begin
    if (state == CAPTURE_IR) begin
      ir_sr <= adp_instr_t'(1);
    end else if (state == SHIFT_IR) begin
      ir_sr <= {tdi, ir_sr[`ADP_IR_WIDTH-1:1]};
    end
  end

  ////////////////////////////////////////////////////////////
  // Data registers
  ////////////////////////////////////////////////////////////

  assign sel_addr = (ir == `ADP_IR_ADDR_WRITE);
  assign sel_data = (ir == `ADP_IR_DEBUG_WRITE) || (ir == `ADP_IR_DEBUG_READ);

  // IDCODE and bypass reload on every capture
  always_ff @(posedge tck) begin
    if (state == CAPTURE_DR) begin
      idcode_sr <= `ADP_IDCODE;
      bypass_sr <= 1'b0;
    end else if (state == SHIFT_DR) begin
      idcode_sr <= {tdi, idcode_sr[`ADP_DATA_WIDTH-1:1]};
      bypass_sr <= tdi;
    end
  end

  // Address shifts only under ADDR_WRITE, so it holds between accesses
  always_ff @(posedge tck) begin
    if (state == SHIFT_DR && sel_addr) begin
      addr_sr <= {tdi, addr_sr[`ADP_ADDR_WIDTH-1:1]};
    end
  end

  // Read data from the bus lands here for a later shift
  always_ff @(posedge tck) begin
    if (dbg_done && ir == `ADP_IR_DEBUG_READ) begin
      data_sr <= dbg_rdata;
    end else if (state == SHIFT_DR && sel_data) begin
      data_sr <= {tdi, data_sr[`ADP_DATA_WIDTH-1:1]};
    end
  end

  always_comb begin
    case (ir)
      `ADP_IR_DEVICE_ID_READ: dr_lsb = idcode_sr[0];
      `ADP_IR_ADDR_WRITE:     dr_lsb = addr_sr[0];
      `ADP_IR_DEBUG_WRITE,
      `ADP_IR_DEBUG_READ:     dr_lsb = data_sr[0];
      `ADP_IR_BYPASS_MODE:    dr_lsb = bypass_sr;
      default:                dr_lsb = bypass_sr;
    endcase
  end

  // TDO launches on the falling edge
  always_ff @(negedge tck) begin
    if (!rst_n) begin
      tdo <= 1'b0;
    end else if (state == SHIFT_IR) begin
      tdo <= ir_sr[0];
    end else if (state == SHIFT_DR) begin
      tdo <= dr_lsb;
    end else begin
      tdo <= 1'b0;
    end
  end

  // Write fires on Update-DR, read fires as DEBUG_READ is applied
  assign dbg_req   = (state == UPDATE_DR && ir == `ADP_IR_DEBUG_WRITE) ||
                     (state == UPDATE_IR && ir_sr == `ADP_IR_DEBUG_READ);
  assign dbg_we    = (state == UPDATE_DR);
  assign dbg_addr  = addr_sr;
  assign dbg_wdata = data_sr;

endmodule

// ==== hdl/adp_top.sv ====
`timescale 1ns/1ps

module adp_top (
  input  logic               tck,
  input  logic               rst_n,
  input  logic               tms,
  input  logic               tdi,
  output logic               tdo,
  output logic               dbg_busy,
  // Processor AXI4-Lite port
  input  adp_pkg::adp_addr_t cpu_awaddr,
  input  logic               cpu_awvalid,
  output logic               cpu_awready,
  input  adp_pkg::adp_data_t cpu_wdata,
  input  logic               cpu_wvalid,
  output logic               cpu_wready,
  output adp_pkg::adp_resp_t cpu_bresp,
  output logic               cpu_bvalid,
  input  logic               cpu_bready,
  input  adp_pkg::adp_addr_t cpu_araddr,
  input  logic               cpu_arvalid,
  output logic               cpu_arready,
  output adp_pkg::adp_data_t cpu_rdata,
  output adp_pkg::adp_resp_t cpu_rresp,
  output logic               cpu_rvalid,
  input  logic               cpu_rready
);
  import adp_pkg::*;

  // TAP to debug master
  logic      dbg_req;
  logic      dbg_we;
  adp_addr_t dbg_addr;
  adp_data_t dbg_wdata;
  logic      dbg_done;
  adp_data_t dbg_rdata;

  // Debug master bus
  adp_addr_t dm_awaddr;
  adp_addr_t dm_araddr;
  adp_data_t dm_wdata;
  adp_data_t dm_rdata;
  adp_resp_t dm_bresp;
  adp_resp_t dm_rresp;
  logic      dm_awvalid;
  logic      dm_awready;
  logic      dm_wvalid;
  logic      dm_wready;
  logic      dm_bvalid;
  logic      dm_bready;
  logic      dm_arvalid;
  logic      dm_arready;
  logic      dm_rvalid;
  logic      dm_rready;

  // Arbitrated bus
  adp_addr_t m_awaddr;
  adp_addr_t m_araddr;
  adp_data_t m_wdata;
  adp_data_t m_rdata;
  adp_resp_t m_bresp;
  adp_resp_t m_rresp;
  logic      m_awvalid;
  logic      m_awready;
  logic      m_wvalid;
  logic      m_wready;
  logic      m_bvalid;
  logic      m_bready;
  logic      m_arvalid;
  logic      m_arready;
  logic      m_rvalid;
  logic      m_rready;

  // Port names line up across the hierarchy
  adp_tap i_adp_tap (.*);

  adp_debug_master i_adp_debug_master (.*);

  adp_axil_arbiter i_adp_axil_arbiter (.*);

  adp_debug_target i_adp_debug_target (.*);

endmodule

// ==== include/adp_settings.svh ====
`ifndef ADP_SETTINGS_SVH
`define ADP_SETTINGS_SVH

// Datapath widths
`define ADP_IR_WIDTH        4
`define ADP_ADDR_WIDTH      16
`define ADP_DATA_WIDTH      32
`define ADP_SRAM_ADDR_WIDTH 8

// Fixed identification code for DEVICE_ID_READ
`define ADP_IDCODE 32'h1A5D_0F01

// TAP instruction codes
// Codes not listed here fall back to bypass
`define ADP_IR_DEVICE_ID_READ 4'h1
`define ADP_IR_ADDR_WRITE     4'h2
`define ADP_IR_DEBUG_WRITE    4'h3
`define ADP_IR_DEBUG_READ     4'h4
`define ADP_IR_BYPASS_MODE    4'hF

// Debug address map
`define ADP_SRAM_BASE 16'h2000
`define ADP_REG_BASE  16'h4000
`define ADP_PC_ADDR   16'h8000
`define ADP_IR_ADDR   16'h8001

`endif

// ==== sim/tb_adp_top.sv ====
`timescale 1ns/1ps
`include "adp_settings.svh"

module tb_adp_top;
  import adp_pkg::*;

  typedef enum {
    OP_IDCODE,
    OP_BYPASS,
    OP_DBG_WR_RD,
    OP_CPU_WR_DBG_RD,
    OP_DBG_WR_CPU_RD,
    OP_UNMAPPED,
    OP_CONCURRENT
  } op_t;

  localparam int        NUM_TESTS   = 14;
  localparam adp_resp_t RESP_OKAY   = 2'b00;
  localparam adp_resp_t RESP_DECERR = 2'b11;

  logic      tck = 1'b0;
  logic      rst_n;
  logic      tms;
  logic      tdi;
  logic      tdo;
  logic      dbg_busy;
  adp_addr_t cpu_awaddr;
  logic      cpu_awvalid;
  logic      cpu_awready;
  adp_data_t cpu_wdata;
  logic      cpu_wvalid;
  logic      cpu_wready;
  adp_resp_t cpu_bresp;
  logic      cpu_bvalid;
  logic      cpu_bready;
  adp_addr_t cpu_araddr;
  logic      cpu_arvalid;
  logic      cpu_arready;
  adp_data_t cpu_rdata;
  adp_resp_t cpu_rresp;
  logic      cpu_rvalid;
  logic      cpu_rready;

  // Test table, one row per index
  string     test_name [NUM_TESTS];
  op_t       test_op   [NUM_TESTS];
  adp_addr_t test_addr [NUM_TESTS];
  adp_data_t test_data [NUM_TESTS];
  int        n_entries = 0;

  int          check_errors   = 0;
  int          timeout_errors = 0;
  logic [31:0] rng_state      = 32'd39170;

  adp_top i_adp_top (.*);

  // 8 ns test clock
  always #4 tck = ~tck;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // xorshift32
  function automatic adp_data_t next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic add_entry(input string name, input op_t op, input adp_addr_t addr);
    test_name[n_entries] = name;
    test_op[n_entries]   = op;
    test_addr[n_entries] = addr;
    test_data[n_entries] = next_random();
    n_entries++;
  endtask

  // Bypass runs first so the TAP reset has a non-IDCODE instruction to clear
  task automatic build_table();
    add_entry("bypass",           OP_BYPASS,        16'h0000);
    add_entry("idcode_tap_reset", OP_IDCODE,        16'h0000);
    add_entry("sram_first",       OP_DBG_WR_RD,     16'h2000);
    add_entry("sram_mid",         OP_DBG_WR_RD,     16'h2057);
    add_entry("sram_last",        OP_DBG_WR_RD,     16'h20FF);
    add_entry("reg_0",            OP_DBG_WR_RD,     16'h4000);
    add_entry("reg_1",            OP_DBG_WR_RD,     16'h4001);
    add_entry("reg_31",           OP_DBG_WR_RD,     16'h401F);
    add_entry("pc",               OP_DBG_WR_RD,     16'h8000);
    add_entry("instr",            OP_DBG_WR_RD,     16'h8001);
    add_entry("cpu_wr_dbg_rd",    OP_CPU_WR_DBG_RD, 16'h2010);
    add_entry("dbg_wr_cpu_rd",    OP_DBG_WR_CPU_RD, 16'h4005);
    add_entry("unmapped",         OP_UNMAPPED,      16'h1000);
    add_entry("concurrent",       OP_CONCURRENT,    16'h2020);
  endtask

  task automatic check_value(input string name, input string what,
                             input adp_data_t expected, input adp_data_t actual);
    assert (actual === expected) else begin
      check_errors++;
      $display("Fail %s: %s expected %h actual %h", name, what, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // TAP driver
  ////////////////////////////////////////////////////////////

  // One tck cycle, entered and left 1 ns after the rising edge
  // TDO seen here was launched on the falling edge of that cycle
  task automatic tap_step(input logic tms_v, input logic tdi_v, output logic tdo_v);
    tms = tms_v;
    tdi = tdi_v;
    @(posedge tck);
    #1;
    tdo_v = tdo;
  endtask

  // Five ones reach Test-Logic-Reset, then park in Run-Test/Idle
  task automatic tap_reset();
    logic b;
    repeat (5) tap_step(1'b1, 1'b0, b);
    tap_step(1'b0, 1'b0, b);
  endtask

  // IR shifts LSB first, from and back to Run-Test/Idle
  task automatic write_ir(input adp_instr_t code);
    logic b;
    tap_step(1'b1, 1'b0, b);
    tap_step(1'b1, 1'b0, b);
    tap_step(1'b0, 1'b0, b);
    tap_step(1'b0, 1'b0, b);
    for (int i = 0; i < `ADP_IR_WIDTH; i++) begin
      tap_step(i == `ADP_IR_WIDTH - 1, code[i], b);
    end
    // Exit1-IR to Update-IR to idle
    tap_step(1'b1, 1'b0, b);
    tap_step(1'b0, 1'b0, b);
  endtask

  task automatic shift_dr(input int len, input adp_data_t din, output adp_data_t dout);
    logic b;
    dout = '0;
    tap_step(1'b1, 1'b0, b);
    tap_step(1'b0, 1'b0, b);
    tap_step(1'b0, 1'b0, b);
    // Last bit leaves Shift-DR
    for (int i = 0; i < len; i++) begin
      tap_step(i == len - 1, din[i], b);
      dout[i] = b;
    end
    tap_step(1'b1, 1'b0, b);
    tap_step(1'b0, 1'b0, b);
  endtask

  // Idle in Run-Test/Idle until the bus access is over
  task automatic wait_idle();
    logic b;
    while (dbg_busy) begin
      tap_step(1'b0, 1'b0, b);
    end
  endtask

  task automatic debug_set_addr(input adp_addr_t addr);
    adp_data_t unused;
    write_ir(`ADP_IR_ADDR_WRITE);
    shift_dr(`ADP_ADDR_WIDTH, adp_data_t'(addr), unused);
  endtask

  task automatic debug_write(input adp_data_t data);
    adp_data_t unused;
    write_ir(`ADP_IR_DEBUG_WRITE);
    shift_dr(`ADP_DATA_WIDTH, data, unused);
    wait_idle();
  endtask

  // Read is issued on Update-IR, data comes out on the next DR scan
  task automatic debug_read(output adp_data_t data);
    write_ir(`ADP_IR_DEBUG_READ);
    wait_idle();
    shift_dr(`ADP_DATA_WIDTH, '0, data);
  endtask

  ////////////////////////////////////////////////////////////
  // Processor port driver
  ////////////////////////////////////////////////////////////

  // Valids rise without waiting for ready and drop after the handshake
  task automatic cpu_write(input adp_addr_t addr, input adp_data_t data,
                           output adp_resp_t resp);
    logic aw_hs;
    logic w_hs;
    cpu_awaddr  = addr;
    cpu_wdata   = data;
    cpu_awvalid = 1'b1;
    cpu_wvalid  = 1'b1;
    cpu_bready  = 1'b1;
    while (cpu_awvalid || cpu_wvalid) begin
      aw_hs = cpu_awvalid && cpu_awready;
      w_hs  = cpu_wvalid && cpu_wready;
      @(posedge tck);
      #1;
      if (aw_hs) cpu_awvalid = 1'b0;
      if (w_hs) cpu_wvalid = 1'b0;
    end
    while (!cpu_bvalid) begin
      @(posedge tck);
      #1;
    end
    resp = cpu_bresp;
    @(posedge tck);
    #1;
    cpu_bready = 1'b0;
  endtask

  task automatic cpu_read(input adp_addr_t addr, output adp_data_t data,
                          output adp_resp_t resp);
    logic ar_hs;
    cpu_araddr  = addr;
    cpu_arvalid = 1'b1;
    cpu_rready  = 1'b1;
    while (cpu_arvalid) begin
      ar_hs = cpu_arready;
      @(posedge tck);
      #1;
      if (ar_hs) cpu_arvalid = 1'b0;
    end
    while (!cpu_rvalid) begin
      @(posedge tck);
      #1;
    end
    data = cpu_rdata;
    resp = cpu_rresp;
    @(posedge tck);
    #1;
    cpu_rready = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    adp_data_t got;
    adp_data_t cpu_got;
    adp_data_t data2;
    adp_data_t expected;
    adp_resp_t resp;
    logic      b;
    rst_n       = 1'b0;
    tms         = 1'b1;
    tdi         = 1'b0;
    cpu_awaddr  = '0;
    cpu_awvalid = 1'b0;
    cpu_wdata   = '0;
    cpu_wvalid  = 1'b0;
    cpu_bready  = 1'b0;
    cpu_araddr  = '0;
    cpu_arvalid = 1'b0;
    cpu_rready  = 1'b0;
    build_table();
    repeat (16) @(posedge tck);
    #1;
    rst_n = 1'b1;
    // Busy, TDO and every processor-side ready or valid
    check_value("reset", "idle outputs", '0, 32'({dbg_busy, tdo, cpu_awready, cpu_wready,
                                                cpu_bvalid, cpu_arready, cpu_rvalid}));
    // Leave Test-Logic-Reset, IDCODE is already selected
    tap_step(1'b0, 1'b0, b);
    shift_dr(32, '0, got);
    check_value("reset", "idcode", `ADP_IDCODE, got);

    for (int t = 0; t < NUM_TESTS; t++) begin
      case (test_op[t])
        OP_IDCODE: begin
          tap_reset();
          shift_dr(32, test_data[t], got);
          check_value(test_name[t], "idcode", `ADP_IDCODE, got);
        end
        // One bit late, the captured zero leads
        OP_BYPASS: begin
          write_ir(`ADP_IR_BYPASS_MODE);
          shift_dr(32, test_data[t], got);
          check_value(test_name[t], "tdo", {test_data[t][30:0], 1'b0}, got);
        end
        OP_DBG_WR_RD: begin
          debug_set_addr(test_addr[t]);
          debug_write(test_data[t]);
          debug_read(got);
          // Register 0 is fixed at zero
          expected = (test_addr[t] == `ADP_REG_BASE) ? '0 : test_data[t];
          check_value(test_name[t], "debug read", expected, got);
        end
        OP_CPU_WR_DBG_RD: begin
          cpu_write(test_addr[t], test_data[t], resp);
          check_value(test_name[t], "bresp", 32'(RESP_OKAY), 32'(resp));
          debug_set_addr(test_addr[t]);
          debug_read(got);
          check_value(test_name[t], "debug read", test_data[t], got);
        end
        OP_DBG_WR_CPU_RD: begin
          debug_set_addr(test_addr[t]);
          debug_write(test_data[t]);
          cpu_read(test_addr[t], cpu_got, resp);
          check_value(test_name[t], "cpu read", test_data[t], cpu_got);
          check_value(test_name[t], "rresp", 32'(RESP_OKAY), 32'(resp));
        end
        OP_UNMAPPED: begin
          cpu_read(test_addr[t], cpu_got, resp);
          check_value(test_name[t], "cpu read", '0, cpu_got);
          check_value(test_name[t], "rresp", 32'(RESP_DECERR), 32'(resp));
          cpu_write(test_addr[t], test_data[t], resp);
          check_value(test_name[t], "bresp", 32'(RESP_DECERR), 32'(resp));
        end
        OP_CONCURRENT: begin
          // Neighbour word gets known data for the processor read
          data2 = next_random();
          cpu_write(test_addr[t] + 16'd1, data2, resp);
          debug_set_addr(test_addr[t]);
          fork
            debug_write(test_data[t]);
            begin
              // Raise the read once the debug write is under way
              while (!dbg_busy) begin
                @(posedge tck);
                #1;
              end
              @(posedge tck);
              #1;
              cpu_read(test_addr[t] + 16'd1, cpu_got, resp);
            end
          join
          check_value(test_name[t], "cpu read", data2, cpu_got);
          check_value(test_name[t], "rresp", 32'(RESP_OKAY), 32'(resp));
          debug_read(got);
          check_value(test_name[t], "debug read", test_data[t], got);
        end
        default: begin
          check_errors++;
          $display("Test %s has no known operation", test_name[t]);
        end
      endcase
    end

    $display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Budget of 400 cycles per table row after reset
  initial begin : watchdog
    repeat (16 + NUM_TESTS * 400) @(posedge tck);
    timeout_errors++;
    $display("Timeout: the tests did not finish within %0d cycles", 16 + NUM_TESTS * 400);
    $display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
hdl/adp_pkg.sv
hdl/adp_tap.sv
hdl/adp_debug_master.sv
hdl/adp_axil_arbiter.sv
hdl/adp_debug_target.sv
hdl/adp_top.sv
sim/tb_adp_top.sv
